//--- files.f
logic/hisPkg.sv
logic/ctrlPkg.sv
logic/dataFormatter.sv
logic/histogramMemory.sv
logic/acqCounter.sv
logic/hisBuilderFSM.sv
logic/peakDetecter.sv
logic/algebraicBlock.sv
logic/hisBuilderTop.sv
sim/hisBuilder_assert.sv
sim/hisBuilderTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= hisBuilderTb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/hisBuilderTb.sv
module hisBuilderTb;

    timeunit 1ns;
    timeprecision 100ps;

    logic              clk;
    logic              reset;
    logic              wrEn;
    hisPkg::timestampT roughData;
    logic              acqActive;
    logic              peakDone;
    hisPkg::binT       peakCH;
    hisPkg::binT       peakFH;
    hisPkg::timestampT peakTime;
    hisPkg::timestampT THminus;
    hisPkg::timestampT THpositive;

    integer seed;
    int     errorCount;

    // reference histograms, one per pass
    int coarseHist [2**hisPkg::Nb];
    int fineHist [2**hisPkg::Nb];

    // current measurement
    int                target;
    bit                uniformData;
    int                expCH;
    int                expFH;
    hisPkg::timestampT expTHminus;

    hisBuilderTop uut (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .roughData  (roughData),
        .acqActive  (acqActive),
        .peakDone   (peakDone),
        .peakCH     (peakCH),
        .peakFH     (peakFH),
        .peakTime   (peakTime),
        .THminus    (THminus),
        .THpositive (THpositive)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopWithError(input string line);
        errorCount++;
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkValue(input string what, input int got, input int expected);
        assert (got == expected)
        else stopWithError($sformatf("MISMATCH at %0d ns: %s is %0d, expected %0d",
                                     $time, what, got, expected));
    endtask

    // bound control assertions, looked at between edges
    always @(negedge clk) begin
        assert (uut.hisBuilderAssertU0.failCount == 0)
        else stopWithError($sformatf("a bound control assertion failed before %0d ns",
                                     $time));
    end

    task automatic randomBelow(input int limit, output int value);
        value = int'($unsigned($random(seed)) % $unsigned(limit));
    endtask

    // lowest bin holding the largest count
    function automatic int peakOf(input int hist [2**hisPkg::Nb]);
        int best;
        best = 0;
        for (int b = 1; b < 2**hisPkg::Nb; b++) begin
            if (hist[b] > hist[best]) begin
                best = b;
            end
        end
        return best;
    endfunction

    // either near the target or anywhere in the range
    task automatic nextTimestamp(output hisPkg::timestampT ts);
        int pick;
        int jitter;
        randomBelow(4, pick);
        randomBelow(7, jitter);
        if (uniformData || pick == 0) begin
            ts = hisPkg::timestampT'($random(seed));
        end else begin
            // +-3 codes, wraps at the range ends
            ts = hisPkg::timestampT'(target + jitter - 3);
        end
    endtask

    task automatic waitAcqActive();
        int cycles;
        cycles = 0;
        while (!acqActive) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 64) begin
                stopWithError($sformatf("timed out at %0d ns waiting for acqActive", $time));
            end
        end
    endtask

    task automatic waitPeakDone(output int cycles);
        cycles = 0;
        while (!peakDone) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 64) begin
                stopWithError($sformatf("timed out at %0d ns waiting for peakDone", $time));
            end
        end
    endtask

    // strobes only while the DUT accepts, model updated alongside
    task automatic sendSamples(input bit fine, input int count);
        hisPkg::timestampT ts;
        hisPkg::timestampT offset;
        int idle;
        for (int n = 0; n < count; n++) begin
            waitAcqActive();
            nextTimestamp(ts);
            wrEn = 1'b1;
            roughData = ts;
            if (!fine) begin
                coarseHist[ts >> hisPkg::coarseShift]++;
            end else begin
                // below the window wraps to a large offset
                offset = ts - expTHminus;
                if (offset < hisPkg::windowSpan) begin
                    fineHist[offset >> hisPkg::fineShift]++;
                end
            end
            @(posedge clk);
            #1;
            wrEn = 1'b0;
            // gaps between strobes, none after the last one
            if (n < count - 1) begin
                randomBelow(3, idle);
                repeat (idle) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
    endtask

    task automatic startMeasurement(input int index);
        randomBelow(2**hisPkg::Np, target);
        // flat data now and then, ties likely
        uniformData = (index % 20 == 7);
        for (int b = 0; b < 2**hisPkg::Nb; b++) begin
            coarseHist[b] = 0;
            fineHist[b] = 0;
        end
    endtask

    task automatic runMeasurement(input int index);
        int waited;
        startMeasurement(index);
        waitAcqActive();
        sendSamples(1'b0, ctrlPkg::acqLength);
        checkValue("acqActive after coarse pass", acqActive, 0);
        expCH = peakOf(coarseHist);
        expTHminus = hisPkg::timestampT'(expCH * hisPkg::windowSpan);
        // fine acquisition opens once the window is loaded
        waitAcqActive();
        checkValue("peakCH at window load", peakCH, expCH);
        checkValue("THminus", THminus, expTHminus);
        checkValue("THpositive", THpositive, expTHminus + hisPkg::windowSpan - 1);
        sendSamples(1'b1, ctrlPkg::acqLength);
        checkValue("acqActive after fine pass", acqActive, 0);
        expFH = peakOf(fineHist);
        waitPeakDone(waited);
        // 64th fine strobe to result is fixed
        checkValue("cycles from last fine strobe to peakDone", waited + 1, 18);
        checkValue("peakCH", peakCH, expCH);
        checkValue("peakFH", peakFH, expFH);
        checkValue("peakTime", peakTime, expTHminus + (expFH << hisPkg::fineShift));
    endtask

    // abort a fine pass part way
    task automatic resetDuringFinePass();
        int partial;
        startMeasurement(1);
        waitAcqActive();
        sendSamples(1'b0, ctrlPkg::acqLength);
        expCH = peakOf(coarseHist);
        expTHminus = hisPkg::timestampT'(expCH * hisPkg::windowSpan);
        waitAcqActive();
        randomBelow(40, partial);
        sendSamples(1'b1, partial + 8);
        reset = 1'b1;
        wrEn = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #1;
            // back in coarse acquisition, still accepting
            checkValue("acqActive during reset", acqActive, 1);
        end
        reset = 1'b0;
        checkValue("peakDone after reset", peakDone, 0);
    endtask

    initial begin
        seed = 32'h569b_914d;
        errorCount = 0;
        reset = 1'b1;
        wrEn = 1'b0;
        roughData = '0;
        target = 0;
        uniformData = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        checkValue("acqActive after reset", acqActive, 1);
        checkValue("peakDone after reset", peakDone, 0);

        // back to back results
        for (int m = 0; m < 200; m++) begin
            runMeasurement(m);
        end

        resetDuringFinePass();
        // fresh model after the abort
        runMeasurement(200);
        runMeasurement(201);

        if (errorCount == 0 && uut.hisBuilderAssertU0.failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sim/hisBuilder_assert.sv
module hisBuilderAssert (
    input logic              clk,
    input logic              reset,
    input logic              acqActive,
    input logic              hisNum,
    input logic              peakDone,
    input hisPkg::timestampT THminus,
    input hisPkg::timestampT THpositive
);

    timeunit 1ns;
    timeprecision 100ps;

    // failed properties so far, watched by the testbench
    int failCount = 0;

    // result strobe is a single cycle
    peakDoneOnePulse: assert property (@(posedge clk) disable iff (reset)
        peakDone |=> !peakDone)
        else begin
            $error("peakDone held longer than one cycle");
            failCount++;
        end

    // low from the cycle after the last strobe through the result, 18 cycles
    noAcqBeforeDone: assert property (@(posedge clk) disable iff (reset)
        peakDone |-> !acqActive && !$past(acqActive) && !$past(acqActive, 17))
        else begin
            $error("acqActive high between fine scan and peakDone");
            failCount++;
        end

    // window is 64 codes wide during the fine pass
    windowWidth: assert property (@(posedge clk) disable iff (reset)
        (acqActive && hisNum) |-> THpositive == hisPkg::timestampT'(THminus + 63))
        else begin
            $error("THpositive not 63 above THminus in the fine pass");
            failCount++;
        end

endmodule

bind hisBuilderTop hisBuilderAssert hisBuilderAssertU0 (
    .clk        (clk),
    .reset      (reset),
    .acqActive  (acqActive),
    .hisNum     (hisNum),
    .peakDone   (peakDone),
    .THminus    (THminus),
    .THpositive (THpositive)
);

//--- logic/hisBuilderTop.sv
module hisBuilderTop (
    input  logic              clk,
    input  logic              reset,
    input  logic              wrEn,
    input  hisPkg::timestampT roughData,
    output logic              acqActive,
    output logic              peakDone,
    output hisPkg::binT       peakCH,
    output hisPkg::binT       peakFH,
    output hisPkg::timestampT peakTime,
    output hisPkg::timestampT THminus,
    output hisPkg::timestampT THpositive
);

    hisPkg::binT   addr;
    logic          inWindow;
    logic          hisNum;
    logic          writeStrobe;
    logic          acqFull;
    logic          scanActive;
    logic          scanFirst;
    logic          scanEnd;
    logic          loadWindow;
    logic          clearBins;
    hisPkg::binT   scanIdx;
    hisPkg::countT scanCount;
    hisPkg::binT   peakBin;

    // coarse pass keeps every sample, fine pass only the windowed ones
    assign writeStrobe = wrEn && acqActive && (!hisNum || inWindow);

    dataFormatter dataFormatterU0 (
        .roughData (roughData),
        .hisNum    (hisNum),
        .THminus   (THminus),
        .addr      (addr),
        .inWindow  (inWindow)
    );

    histogramMemory histogramMemoryU0 (
        .clk         (clk),
        .reset       (reset),
        .writeStrobe (writeStrobe),
        .addr        (addr),
        .clearBins   (clearBins),
        .scanIdx     (scanIdx),
        .scanCount   (scanCount)
    );

    acqCounter acqCounterU0 (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .acqActive  (acqActive),
        .scanActive (scanActive),
        .acqFull    (acqFull),
        .scanIdx    (scanIdx),
        .scanEnd    (scanEnd)
    );

    // scanLast is folded into the FSM's own sequencing
    hisBuilderFSM hisBuilderFSMU0 (
        .clk        (clk),
        .reset      (reset),
        .acqFull    (acqFull),
        .scanEnd    (scanEnd),
        .peakBin    (peakBin),
        .acqActive  (acqActive),
        .hisNum     (hisNum),
        .scanActive (scanActive),
        .scanFirst  (scanFirst),
        .scanLast   (),
        .loadWindow (loadWindow),
        .clearBins  (clearBins),
        .peakDone   (peakDone),
        .peakFH     (peakFH)
    );

    peakDetecter peakDetecterU0 (
        .clk        (clk),
        .reset      (reset),
        .scanActive (scanActive),
        .scanFirst  (scanFirst),
        .scanIdx    (scanIdx),
        .scanCount  (scanCount),
        .peakBin    (peakBin)
    );

    // window span is fixed, delta left open
    algebraicBlock algebraicBlockU0 (
        .clk        (clk),
        .reset      (reset),
        .loadWindow (loadWindow),
        .peakBin    (peakBin),
        .peakFH     (peakFH),
        .THminus    (THminus),
        .THpositive (THpositive),
        .delta      (),
        .peakCH     (peakCH),
        .peakTime   (peakTime)
    );

endmodule

//--- logic/algebraicBlock.sv
module algebraicBlock (
    input  logic              clk,
    input  logic              reset,
    input  logic              loadWindow,
    input  hisPkg::binT       peakBin,
    input  hisPkg::binT       peakFH,
    output hisPkg::timestampT THminus,
    output hisPkg::timestampT THpositive,
    output hisPkg::timestampT delta,
    output hisPkg::binT       peakCH,
    output hisPkg::timestampT peakTime
);

    // first code of the coarse peak bin
    hisPkg::timestampT windowStart;

    assign windowStart = hisPkg::timestampT'(peakBin) << hisPkg::coarseShift;

    always_ff @(posedge clk) begin
        if (reset) begin
            THminus <= '0;
            THpositive <= '0;
            delta <= '0;
            peakCH <= '0;
        end else if (loadWindow) begin
            // window covers exactly the coarse peak bin
            THminus <= windowStart;
            THpositive <= windowStart + hisPkg::timestampT'(hisPkg::windowSpan - 1);
            delta <= hisPkg::timestampT'(hisPkg::windowSpan);
            peakCH <= peakBin;
        end
    end

    // lower edge of the fine peak bin, absolute code
    assign peakTime = THminus + (hisPkg::timestampT'(peakFH) << hisPkg::fineShift);

endmodule

//--- logic/peakDetecter.sv
module peakDetecter (
    input  logic          clk,
    input  logic          reset,
    input  logic          scanActive,
    input  logic          scanFirst,
    input  hisPkg::binT   scanIdx,
    input  hisPkg::countT scanCount,
    output hisPkg::binT   peakBin
);

    // largest count seen so far in this sweep
    hisPkg::countT maxCount;

    // strict compare, so an equal count later on keeps the lower bin
    logic newPeak;

    assign newPeak = scanCount > maxCount;

    always_ff @(posedge clk) begin
        if (reset) begin
            maxCount <= '0;
            peakBin <= '0;
        end else if (scanFirst) begin
            // bin 0 seeds the running maximum
            maxCount <= scanCount;
            peakBin <= '0;
        end else if (scanActive && newPeak) begin
            maxCount <= scanCount;
            peakBin <= scanIdx;
        end
    end

    // result held until the next sweep seeds it again
    // valid the cycle after the last bin

endmodule

//--- logic/hisBuilderFSM.sv
module hisBuilderFSM (
    input  logic        clk,
    input  logic        reset,
    input  logic        acqFull,
    input  logic        scanEnd,
    input  hisPkg::binT peakBin,
    output logic        acqActive,
    output logic        hisNum,
    output logic        scanActive,
    output logic        scanFirst,
    output logic        scanLast,
    output logic        loadWindow,
    output logic        clearBins,
    output logic        peakDone,
    output hisPkg::binT peakFH
);

    ctrlPkg::hisStateT state;
    ctrlPkg::hisStateT nextState;

    // set from the window load until the result is out
    // tells the two uses of stWindow apart
    logic finePass;

    // extra cycle after the fine sweep while the peak detector settles
    logic scanTail;

    always_comb begin
        nextState = state;
        case (state)
            ctrlPkg::stAcqCH: begin
                if (acqFull) nextState = ctrlPkg::stScanCH;
            end
            ctrlPkg::stScanCH: begin
                if (scanLast) nextState = ctrlPkg::stWindow;
            end
            ctrlPkg::stWindow: begin
                nextState = finePass ? ctrlPkg::stAcqCH : ctrlPkg::stAcqFH;
            end
            ctrlPkg::stAcqFH: begin
                if (acqFull) nextState = ctrlPkg::stScanFH;
            end
            ctrlPkg::stScanFH: begin
                if (scanTail) nextState = ctrlPkg::stWindow;
            end
            default: nextState = ctrlPkg::stAcqCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctrlPkg::stAcqCH;
            finePass <= 1'b0;
            scanTail <= 1'b0;
            scanFirst <= 1'b0;
        end else begin
            state <= nextState;
            // window load starts the fine pass, result ends it
            if (state == ctrlPkg::stWindow) begin
                finePass <= !finePass;
            end
            scanTail <= (state == ctrlPkg::stScanFH) && scanLast;
            // first sweep cycle follows the completing strobe
            scanFirst <= acqActive && acqFull;
        end
    end

    // output stage for the fine peak
    // peakBin is settled in the tail cycle, shown with peakDone one cycle on
    always_ff @(posedge clk) begin
        if (reset) begin
            peakFH <= '0;
        end else if (scanTail) begin
            peakFH <= peakBin;
        end
    end

    // state decode
    assign acqActive = (state == ctrlPkg::stAcqCH) || (state == ctrlPkg::stAcqFH);
    assign hisNum = finePass;
    assign scanActive = (state == ctrlPkg::stScanCH)
                     || ((state == ctrlPkg::stScanFH) && !scanTail);
    assign scanLast = scanEnd;
    assign loadWindow = (state == ctrlPkg::stWindow) && !finePass;
    assign peakDone = (state == ctrlPkg::stWindow) && finePass;
    // bins wiped in both gap cycles
    assign clearBins = (state == ctrlPkg::stWindow);

endmodule

//--- logic/acqCounter.sv
module acqCounter (
    input  logic        clk,
    input  logic        reset,
    input  logic        wrEn,
    input  logic        acqActive,
    input  logic        scanActive,
    output logic        acqFull,
    output hisPkg::binT scanIdx,
    output logic        scanEnd
);

    // every accepted strobe, in or out of the fine window
    hisPkg::countT sampleCount;
    logic          accept;

    assign accept = wrEn && acqActive;

    // high with the strobe that completes the pass and while the count sits there
    // lets the FSM leave acquisition the very next cycle
    assign acqFull = (sampleCount == hisPkg::countT'(ctrlPkg::acqLength))
                  || (accept && sampleCount == hisPkg::countT'(ctrlPkg::acqLength - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            sampleCount <= '0;
        end else if (!acqActive) begin
            // zero outside acquisition, so each pass starts fresh
            sampleCount <= '0;
        end else if (accept) begin
            sampleCount <= sampleCount + 1'b1;
        end
    end

    // last bin of the sweep
    assign scanEnd = scanActive && (scanIdx == {hisPkg::Nb{1'b1}});

    always_ff @(posedge clk) begin
        if (reset) begin
            scanIdx <= '0;
        end else if (scanActive) begin
            // back to bin 0 ready for the next sweep
            scanIdx <= scanEnd ? '0 : scanIdx + 1'b1;
        end
    end

endmodule

//--- logic/histogramMemory.sv
module histogramMemory (
    input  logic          clk,
    input  logic          reset,
    input  logic          writeStrobe,
    input  hisPkg::binT   addr,
    input  logic          clearBins,
    input  hisPkg::binT   scanIdx,
    output hisPkg::countT scanCount
);

    // one counter per bin, shared by both passes
    hisPkg::countT binCount [2**hisPkg::Nb];

    always_ff @(posedge clk) begin
        if (reset || clearBins) begin
            // wipe the whole histogram before the next pass
            for (int i = 0; i < 2**hisPkg::Nb; i++) begin
                binCount[i] <= '0;
            end
        end else if (writeStrobe) begin
            // new count visible the cycle after the strobe
            binCount[addr] <= binCount[addr] + 1'b1;
        end
    end

    // scan read port, no latency
    // the peak detector samples it in the same cycle
    assign scanCount = binCount[scanIdx];

endmodule

//--- logic/dataFormatter.sv
module dataFormatter (
    input  hisPkg::timestampT roughData,
    input  logic              hisNum,
    input  hisPkg::timestampT THminus,
    output hisPkg::binT       addr,
    output logic              inWindow
);

    // distance from the window start, wraps below THminus
    hisPkg::timestampT offset;

    // offset held back by the fine bin width
    hisPkg::timestampT fineOffset;

    always_comb begin
        offset = roughData - THminus;
        fineOffset = offset >> hisPkg::fineShift;
    end

    // early timestamps wrap to a large offset, so one compare covers both edges
    // only meaningful in the fine pass
    assign inWindow = hisNum && (offset < hisPkg::timestampT'(hisPkg::windowSpan));

    always_comb begin
        if (hisNum) begin
            // fine pass, 4 codes per bin inside the window
            addr = hisPkg::binT'(fineOffset);
        end else begin
            // coarse pass, top bits of the raw timestamp
            addr = hisPkg::binT'(roughData >> hisPkg::coarseShift);
        end
    end

endmodule

//--- logic/ctrlPkg.sv
package ctrlPkg;

    // samples per acquisition pass, coarse and fine alike
    localparam int acqLength = 64;

    // histogram builder sequence
    // stWindow is the one-cycle gap after each scan
    typedef enum logic [2:0] {
        stAcqCH,
        stScanCH,
        stWindow,
        stAcqFH,
        stScanFH
    } hisStateT;

endpackage

//--- logic/hisPkg.sv
package hisPkg;

    // timestamp width from the TDC
    localparam int Np = 10;

    // bin address width, 16 bins per histogram
    localparam int Nb = 4;

    // per-bin hit count width
    // 64 samples per pass fit without saturation
    localparam int countWidth = 7;

    // timestamp to coarse bin, 64 codes per bin
    localparam int coarseShift = 6;

    // window offset to fine bin, 4 codes per bin
    localparam int fineShift = 2;

    // fine window width in timestamp codes
    localparam int windowSpan = 64;

    typedef logic [Np-1:0] timestampT;
    typedef logic [Nb-1:0] binT;
    typedef logic [countWidth-1:0] countT;

endpackage
